/* multicore_bus_wrapper.f */
verilog/bus_pkg.sv
verilog/front_side_port.sv
verilog/memory_controller.sv
verilog/apb_requester.sv
verilog/multicore_bus_wrapper.sv
sim/apb_memory_model.sv
sim/apb_requester_properties.sv
sim/multicore_bus_wrapper_tb.sv

/* sim/apb_memory_model.sv */
`timescale 1ns/10ps

// APB completer, word memory with an error region
module apb_memory_model #(
    parameter logic [bus_pkg::ADDR_W-1:0] FAULT_LO = 32'h0000_0300,
    parameter logic [bus_pkg::ADDR_W-1:0] FAULT_HI = 32'h0000_03fc
) (
    input  logic                        CLK,
    // one wait state per stalled cycle
    input  logic                        stall,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [bus_pkg::ADDR_W-1:0]  paddr,
    input  logic [bus_pkg::DATA_W-1:0]  pwdata,
    output logic [bus_pkg::DATA_W-1:0]  prdata,
    output logic                        pready,
    output logic                        pslverr
);

    // 256 words, indexed by the word address
    logic [bus_pkg::DATA_W-1:0] mem [0:255];
    logic                       fault;
    logic                       commit;

    assign fault = (paddr >= FAULT_LO) && (paddr <= FAULT_HI);

    assign pready  = !stall;
    // error only in the access phase
    assign pslverr = psel && penable && fault;
    // faulting reads return zero
    assign prdata  = (psel && !fault) ? mem[paddr[9:2]] : '0;

    // write lands on the completing access cycle
    // fault region never written
    assign commit = psel && penable && pready && pwrite && !fault;

    always @(posedge CLK) begin
        if (commit) begin
            mem[paddr[9:2]] <= pwdata;
        end
    end

endmodule

/* sim/apb_requester_properties.sv */
`timescale 1ns/10ps

// APB protocol checks on the requester outputs
module apb_requester_properties (
    input logic                        CLK,
    input logic                        rst,
    input logic                        psel,
    input logic                        penable,
    input logic                        pready,
    input logic                        pwrite,
    input logic [bus_pkg::ADDR_W-1:0]  paddr,
    input logic [bus_pkg::DATA_W-1:0]  pwdata
);

    // read back by the testbench at the end of the run
    int assert_failures = 0;

    // setup cycle always moves on to access
    a_setup_then_access: assert property (
        @(posedge CLK) disable iff (rst) (psel && !penable) |=> (psel && penable)
    ) else begin
        assert_failures++;
        $error("APB setup cycle not followed by an access cycle");
    end

    // no access phase without a setup cycle before it
    a_access_after_setup: assert property (
        @(posedge CLK) disable iff (rst) $rose(penable) |-> $past(psel && !penable)
    ) else begin
        assert_failures++;
        $error("APB access phase entered without a setup cycle");
    end

    // address phase fields held for the whole transfer
    a_fields_stable: assert property (
        @(posedge CLK) disable iff (rst)
        (psel && !(penable && pready)) |=>
            ($stable(paddr) && $stable(pwrite) && $stable(pwdata))
    ) else begin
        assert_failures++;
        $error("APB paddr, pwrite or pwdata changed while psel was high");
    end

    // transfer ends on pready
    a_penable_drop: assert property (
        @(posedge CLK) disable iff (rst) (penable && pready) |=> !penable
    ) else begin
        assert_failures++;
        $error("APB penable still high after the pready cycle");
    end

endmodule

/* sim/multicore_bus_wrapper_tb.sv */
`timescale 1ns/10ps

module multicore_bus_wrapper_tb;

    // each hart owns 96 words and the top 64 words form the fault region
    localparam int HART_WORDS = 96;
    localparam logic [31:0] FAULT_LO = 32'h0000_0300;
    localparam logic [31:0] FAULT_HI = 32'h0000_03fc;
    localparam int N_RANDOM = 40;
    localparam int N_FAULT = 4;
    localparam int N_FAIR = 8;
    // transfers over all tests and both harts
    localparam int TRANSFERS = 2 * (2 + N_RANDOM + N_FAULT + 2 + N_FAIR);
    // own transfer plus one from the other hart with capped wait states
    localparam int WORST_CYCLES = 18;
    localparam int MAX_CYCLES = 4 * TRANSFERS * WORST_CYCLES;

    logic             CLK;
    logic             rst;
    logic [1:0]       req;
    logic [1:0]       wen;
    logic [1:0][31:0] addr;
    logic [1:0][31:0] wdata;
    logic [1:0]       done;
    logic [1:0][31:0] rdata;
    logic [1:0]       error;
    logic [31:0]      prdata;
    logic             pready;
    logic             pslverr;
    logic             psel;
    logic             penable;
    logic             pwrite;
    logic [31:0]      paddr;
    logic [31:0]      pwdata;
    logic             stall;

    // outstanding request per hart
    // set by the driver and cleared on done
    logic        pend_active [0:1];
    logic        pend_wen    [0:1];
    logic [31:0] pend_addr   [0:1];
    logic [31:0] pend_wdata  [0:1];
    int          issued      [0:1];
    int          completions [0:1];
    int          done_order  [$];

    // reference copy of everything written
    logic [31:0] shadow  [0:255];
    logic        written [0:255];

    logic [31:0] rng_state = 32'h802e_8a9a;
    int          stall_run = 0;
    int          cycle_count = 0;
    int          check_count = 0;
    int          error_count = 0;
    int          check_base;
    int          error_base;
    int          test_num = 0;
    string       test_name;

    multicore_bus_wrapper #(
        .NUM_HARTS(2)
    ) dut_i (
        .CLK(CLK),
        .rst(rst),
        .req(req),
        .wen(wen),
        .addr(addr),
        .wdata(wdata),
        .done(done),
        .rdata(rdata),
        .error(error),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata)
    );

    apb_memory_model #(
        .FAULT_LO(FAULT_LO),
        .FAULT_HI(FAULT_HI)
    ) mem_i (
        .CLK(CLK),
        .stall(stall),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr)
    );

    bind apb_requester apb_requester_properties props_i (
        .CLK(CLK),
        .rst(rst),
        .psel(psel),
        .penable(penable),
        .pready(pready),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata)
    );

    always #20 CLK = ~CLK;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // power-up contents mixing both address halves
    function automatic logic [31:0] initial_word(input logic [31:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5ac3_0f69;
    endfunction

    function automatic logic in_fault_region(input logic [31:0] a);
        return (a >= FAULT_LO) && (a <= FAULT_HI);
    endfunction

    // last word written there or else the power-up pattern
    function automatic logic [31:0] expected_read(input logic [31:0] a);
        return written[a[9:2]] ? shadow[a[9:2]] : initial_word(a);
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, actual, expected);
        end
    endtask

    // random wait states with at most three in a row
    always @(posedge CLK) begin
        logic [31:0] r;
        r = next_random();
        if (!rst && stall_run < 3 && r[0]) begin
            stall <= 1'b1;
            stall_run++;
        end else begin
            stall <= 1'b0;
            stall_run = 0;
        end
    end

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            $display("Timeout: run exceeded %0d cycles without finishing", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    // compare every done pulse against the reference
    always @(negedge CLK) begin
        if (!rst) begin
            for (int h = 0; h < 2; h++) begin
                // every pulse counts toward the hart's completions
                if (done[h]) begin
                    completions[h]++;
                end
                if (done[h] && !pend_active[h]) begin
                    error_count++;
                    $display("Error at %0t: hart %0d pulsed done with no request outstanding",
                             $time, h);
                end else if (done[h]) begin
                    check_value($sformatf("error[%0d]", h), 32'(error[h]),
                                32'(in_fault_region(pend_addr[h])));
                    if (!pend_wen[h] && !in_fault_region(pend_addr[h])) begin
                        check_value($sformatf("rdata[%0d]", h), rdata[h],
                                    expected_read(pend_addr[h]));
                    end
                    if (pend_wen[h] && !in_fault_region(pend_addr[h])) begin
                        written[pend_addr[h][9:2]] = 1'b1;
                        shadow[pend_addr[h][9:2]]  = pend_wdata[h];
                    end
                    pend_active[h] = 1'b0;
                    done_order.push_back(h);
                end
            end
        end
    end

    // fields held until the done pulse and req left high afterwards
    task automatic transfer(input int h, input logic w, input logic [31:0] a,
                            input logic [31:0] d);
        @(posedge CLK);
        req[h]   <= 1'b1;
        wen[h]   <= w;
        addr[h]  <= a;
        wdata[h] <= d;
        pend_wen[h]    = w;
        pend_addr[h]   = a;
        pend_wdata[h]  = d;
        pend_active[h] = 1'b1;
        issued[h]++;
        do begin
            @(negedge CLK);
        end while (!done[h]);
    endtask

    task automatic idle_hart(input int h);
        @(posedge CLK);
        req[h] <= 1'b0;
    endtask

    task automatic check_quiet();
        check_value("done", 32'(done), 32'h0);
        check_value("psel", 32'(psel), 32'h0);
        check_value("penable", 32'(penable), 32'h0);
    endtask

    // ten rising edges with rst high and then a few quiet cycles
    task automatic reset_checks();
        for (int i = 0; i < 9; i++) begin
            @(negedge CLK);
            check_quiet();
        end
        @(posedge CLK);
        rst <= 1'b0;
        repeat (3) begin
            @(negedge CLK);
            check_quiet();
        end
    endtask

    task automatic basic_traffic(input int h);
        logic [31:0] a;
        a = 32'(h * HART_WORDS + 1) << 2;
        transfer(h, 1'b1, a, 32'h1234_5670 + 32'(h));
        transfer(h, 1'b0, a, 32'h0);
        idle_hart(h);
    endtask

    task automatic random_traffic(input int h);
        logic [31:0] r;
        logic [31:0] word;
        for (int n = 0; n < N_RANDOM; n++) begin
            r = next_random();
            word = 32'(h * HART_WORDS) + 32'(r[15:8] % HART_WORDS);
            transfer(h, r[0], word << 2, next_random());
        end
        idle_hart(h);
    endtask

    // errors first and then normal traffic that must still work
    task automatic fault_traffic(input int h);
        logic [31:0] fault_addr;
        logic [31:0] good_addr;
        fault_addr = FAULT_LO + 32'(h) * 32'h80;
        good_addr = 32'(h * HART_WORDS + 5) << 2;
        for (int n = 0; n < N_FAULT / 2; n++) begin
            transfer(h, 1'b1, fault_addr + 32'(n) * 4, next_random());
            transfer(h, 1'b0, fault_addr + 32'(n) * 4, 32'h0);
        end
        transfer(h, 1'b1, good_addr, 32'hc0de_0000 | 32'(h));
        transfer(h, 1'b0, good_addr, 32'h0);
        idle_hart(h);
    endtask

    // back-to-back requests where req never drops in between
    task automatic fairness_traffic(input int h);
        for (int n = 0; n < N_FAIR; n++) begin
            transfer(h, n[0], 32'(h * HART_WORDS + 10 + n) << 2, next_random());
        end
        idle_hart(h);
    endtask

    task automatic start_test(input string name);
        test_num++;
        test_name  = name;
        check_base = check_count;
        error_base = error_count;
    endtask

    task automatic finish_test();
        check_value("hart 0 completions", completions[0], issued[0]);
        check_value("hart 1 completions", completions[1], issued[1]);
        $display("test %0d %s: %0d checks, %0d errors", test_num, test_name,
                 check_count - check_base, error_count - error_base);
    endtask

    initial begin
        CLK   = 1'b0;
        rst   = 1'b1;
        req   = '0;
        wen   = '0;
        addr  = '0;
        wdata = '0;
        stall = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem_i.mem[i] = initial_word(32'(i) << 2);
            written[i]   = 1'b0;
            shadow[i]    = '0;
        end
        for (int h = 0; h < 2; h++) begin
            pend_active[h] = 1'b0;
            issued[h]      = 0;
            completions[h] = 0;
        end

        start_test("reset values");
        reset_checks();
        finish_test();

        start_test("write then read");
        fork
            basic_traffic(0);
            basic_traffic(1);
        join
        finish_test();

        start_test("random concurrent traffic");
        fork
            random_traffic(0);
            random_traffic(1);
        join
        finish_test();

        start_test("fault region");
        fork
            fault_traffic(0);
            fault_traffic(1);
        join
        finish_test();

        start_test("round-robin fairness");
        done_order.delete();
        fork
            fairness_traffic(0);
            fairness_traffic(1);
        join
        check_value("done pulse count", done_order.size(), 2 * N_FAIR);
        for (int i = 1; i < done_order.size(); i++) begin
            check_value("done hart order", done_order[i], 1 - done_order[i-1]);
        end
        finish_test();

        if (dut_i.bt.props_i.assert_failures != 0) begin
            error_count += dut_i.bt.props_i.assert_failures;
            $display("APB protocol assertions failed %0d times",
                     dut_i.bt.props_i.assert_failures);
        end
        $display("summary: %0d tests, %0d checks, %0d errors", test_num, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* verilog/apb_requester.sv */
`timescale 1ns/10ps

// generic bus to APB, setup then access until pready
module apb_requester (
    input  logic                        CLK,
    input  logic                        rst,
    // generic bus
    input  logic                        gb_ren,
    input  logic                        gb_wen,
    input  logic [bus_pkg::ADDR_W-1:0]  gb_addr,
    input  logic [bus_pkg::DATA_W-1:0]  gb_wdata,
    output logic                        gb_busy,
    output logic [bus_pkg::DATA_W-1:0]  gb_rdata,
    output logic                        gb_error,
    // APB
    input  logic [bus_pkg::DATA_W-1:0]  prdata,
    input  logic                        pready,
    input  logic                        pslverr,
    output logic                        psel,
    output logic                        penable,
    output logic                        pwrite,
    output logic [bus_pkg::ADDR_W-1:0]  paddr,
    output logic [bus_pkg::DATA_W-1:0]  pwdata
);

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apb_state_t;

    apb_state_t state;
    logic       start;
    logic       finish;

    // busy low marks the completion cycle, so no restart then
    assign start  = (state == APB_IDLE) && gb_busy && (gb_ren || gb_wen);
    assign finish = (state == APB_ACCESS) && pready;

    assign psel    = (state != APB_IDLE);
    assign penable = (state == APB_ACCESS);

    always_ff @(posedge CLK) begin
        if (rst) begin
            state   <= APB_IDLE;
            gb_busy <= 1'b1;
        end else begin
            case (state)
                APB_IDLE: begin
                    // back to busy after the one completion cycle
                    gb_busy <= 1'b1;
                    if (start) begin
                        state <= APB_SETUP;
                    end
                end
                APB_SETUP: state <= APB_ACCESS;
                APB_ACCESS: begin
                    // wait states stretch this phase
                    if (pready) begin
                        state   <= APB_IDLE;
                        gb_busy <= 1'b0;
                    end
                end
                default: state <= APB_IDLE;
            endcase
        end
    end

    // address phase fields, stable for the whole transfer
    always_ff @(posedge CLK) begin
        if (start) begin
            pwrite <= gb_wen;
            paddr  <= gb_addr;
            pwdata <= gb_wdata;
        end
    end

    // response sampled on the pready cycle
    always_ff @(posedge CLK) begin
        if (finish) begin
            gb_rdata <= prdata;
            gb_error <= pslverr;
        end
    end

endmodule

/* verilog/bus_pkg.sv */
// shared widths and generic-bus status for the multi-hart subsystem
package bus_pkg;

    // address bus width
    localparam int ADDR_W = 32;

    // word width on every bus, no byte enables
    localparam int DATA_W = 32;

    // generic-bus status as seen by the memory controller
    //   L2_IDLE   no transfer granted
    //   L2_BUSY   command on the bus, waiting for completion
    //   L2_ACCESS completed with good response this cycle
    //   L2_ERROR  completed with slave error this cycle
    typedef enum logic [1:0] {
        L2_IDLE   = 2'b00,
        L2_BUSY   = 2'b01,
        L2_ACCESS = 2'b10,
        L2_ERROR  = 2'b11
    } l2_state_t;

    // completion states share the upper bit
    // L2_ACCESS and L2_ERROR both mean the command is finished

endpackage

/* verilog/front_side_port.sv */
`timescale 1ns/10ps

// one hart's request register toward the memory controller
module front_side_port (
    input  logic                        CLK,
    input  logic                        rst,
    // hart side
    input  logic                        req,
    input  logic                        wen,
    input  logic [bus_pkg::ADDR_W-1:0]  addr,
    input  logic [bus_pkg::DATA_W-1:0]  wdata,
    output logic                        done,
    output logic [bus_pkg::DATA_W-1:0]  rdata,
    output logic                        error,
    // controller side
    input  logic                        grant_done,
    input  logic [bus_pkg::DATA_W-1:0]  resp_rdata,
    input  logic                        resp_error,
    output logic                        port_valid,
    output logic                        port_wen,
    output logic [bus_pkg::ADDR_W-1:0]  port_addr,
    output logic [bus_pkg::DATA_W-1:0]  port_wdata
);

    logic accept;
    logic finish;

    // new request only when nothing pending
    // and not in the done cycle, where the hart still holds req
    assign accept = req && !port_valid && !done;

    // controller finished our transfer
    assign finish = port_valid && grant_done;

    // pending flag doubles as the valid toward the controller
    always_ff @(posedge CLK) begin
        if (rst) begin
            port_valid <= 1'b0;
            done       <= 1'b0;
        end else begin
            // done is a single-cycle pulse
            done <= 1'b0;
            if (accept) begin
                port_valid <= 1'b1;
            end else if (finish) begin
                port_valid <= 1'b0;
                done       <= 1'b1;
            end
        end
    end

    // request fields, held until completion
    always_ff @(posedge CLK) begin
        if (accept) begin
            port_wen   <= wen;
            port_addr  <= addr;
            port_wdata <= wdata;
        end
    end

    // response latched with the completion
    // valid to the hart during the done pulse
    always_ff @(posedge CLK) begin
        if (finish) begin
            rdata <= resp_rdata;
            error <= resp_error;
        end
    end

endmodule

/* verilog/memory_controller.sv */
`timescale 1ns/10ps

// round-robin arbiter, one generic-bus transfer at a time
module memory_controller #(
    parameter int NUM_HARTS = 2
) (
    input  logic                                        CLK,
    input  logic                                        rst,
    // front-side ports, one slice per hart
    input  logic [NUM_HARTS-1:0]                        port_valid,
    input  logic [NUM_HARTS-1:0]                        port_wen,
    input  logic [NUM_HARTS-1:0][bus_pkg::ADDR_W-1:0]   port_addr,
    input  logic [NUM_HARTS-1:0][bus_pkg::DATA_W-1:0]   port_wdata,
    output logic [NUM_HARTS-1:0]                        port_grant_done,
    output logic [NUM_HARTS-1:0][bus_pkg::DATA_W-1:0]   port_rdata,
    output logic [NUM_HARTS-1:0]                        port_error,
    // generic bus
    input  logic                                        gb_busy,
    input  logic [bus_pkg::DATA_W-1:0]                  gb_rdata,
    input  logic                                        gb_error,
    output logic                                        gb_ren,
    output logic                                        gb_wen,
    output logic [bus_pkg::ADDR_W-1:0]                  gb_addr,
    output logic [bus_pkg::DATA_W-1:0]                  gb_wdata
);

    // index width, at least one bit
    localparam int HART_W = (NUM_HARTS > 1) ? $clog2(NUM_HARTS) : 1;

    logic               active;
    logic [HART_W-1:0]  grant_idx;
    logic [HART_W-1:0]  rr_ptr;
    logic [HART_W-1:0]  pick_idx;
    logic               pick_found;
    logic               complete;
    bus_pkg::l2_state_t l2state;

    // first valid port at or after the pointer
    always_comb begin
        int unsigned cand;
        pick_found = 1'b0;
        pick_idx   = '0;
        for (int k = 0; k < NUM_HARTS; k++) begin
            cand = (int'(rr_ptr) + k) % NUM_HARTS;
            if (!pick_found && port_valid[cand]) begin
                pick_found = 1'b1;
                pick_idx   = HART_W'(cand);
            end
        end
    end

    // bus status from the requester's busy and error
    always_comb begin
        if (!active) begin
            l2state = bus_pkg::L2_IDLE;
        end else if (gb_busy) begin
            l2state = bus_pkg::L2_BUSY;
        end else if (gb_error) begin
            l2state = bus_pkg::L2_ERROR;
        end else begin
            l2state = bus_pkg::L2_ACCESS;
        end
    end

    assign complete = (l2state == bus_pkg::L2_ACCESS) || (l2state == bus_pkg::L2_ERROR);

    // grant tracking and command strobes
    always_ff @(posedge CLK) begin
        if (rst) begin
            active    <= 1'b0;
            grant_idx <= '0;
            rr_ptr    <= '0;
            gb_ren    <= 1'b0;
            gb_wen    <= 1'b0;
        end else if (complete) begin
            // one idle cycle so the winner's valid can drop
            active <= 1'b0;
            gb_ren <= 1'b0;
            gb_wen <= 1'b0;
        end else if (!active && pick_found) begin
            active    <= 1'b1;
            grant_idx <= pick_idx;
            gb_ren    <= !port_wen[pick_idx];
            gb_wen    <= port_wen[pick_idx];
            // pointer moves past the winner
            if (pick_idx == HART_W'(NUM_HARTS - 1)) begin
                rr_ptr <= '0;
            end else begin
                rr_ptr <= pick_idx + 1'b1;
            end
        end
    end

    // command payload
    always_ff @(posedge CLK) begin
        if (!active && pick_found) begin
            gb_addr  <= port_addr[pick_idx];
            gb_wdata <= port_wdata[pick_idx];
        end
    end

    // response routed to the winner only
    always_comb begin
        for (int i = 0; i < NUM_HARTS; i++) begin
            port_grant_done[i] = complete && (grant_idx == HART_W'(i));
            port_rdata[i]      = (grant_idx == HART_W'(i)) ? gb_rdata : '0;
            port_error[i]      = (grant_idx == HART_W'(i)) && gb_error;
        end
    end

endmodule

/* verilog/multicore_bus_wrapper.sv */
`timescale 1ns/10ps

// harts' front-side ports, joined by the controller onto one APB path
module multicore_bus_wrapper #(
    parameter int NUM_HARTS = 2
) (
    input  logic                                        CLK,
    input  logic                                        rst,
    // hart side, one slice per hart
    input  logic [NUM_HARTS-1:0]                        req,
    input  logic [NUM_HARTS-1:0]                        wen,
    input  logic [NUM_HARTS-1:0][bus_pkg::ADDR_W-1:0]   addr,
    input  logic [NUM_HARTS-1:0][bus_pkg::DATA_W-1:0]   wdata,
    output logic [NUM_HARTS-1:0]                        done,
    output logic [NUM_HARTS-1:0][bus_pkg::DATA_W-1:0]   rdata,
    output logic [NUM_HARTS-1:0]                        error,
    // APB
    input  logic [bus_pkg::DATA_W-1:0]                  prdata,
    input  logic                                        pready,
    input  logic                                        pslverr,
    output logic                                        psel,
    output logic                                        penable,
    output logic                                        pwrite,
    output logic [bus_pkg::ADDR_W-1:0]                  paddr,
    output logic [bus_pkg::DATA_W-1:0]                  pwdata
);

    // port to controller
    logic [NUM_HARTS-1:0]                       port_valid;
    logic [NUM_HARTS-1:0]                       port_wen;
    logic [NUM_HARTS-1:0][bus_pkg::ADDR_W-1:0]  port_addr;
    logic [NUM_HARTS-1:0][bus_pkg::DATA_W-1:0]  port_wdata;
    logic [NUM_HARTS-1:0]                       port_grant_done;
    logic [NUM_HARTS-1:0][bus_pkg::DATA_W-1:0]  port_rdata;
    logic [NUM_HARTS-1:0]                       port_error;

    // generic bus between controller and requester
    logic                       gb_ren;
    logic                       gb_wen;
    logic [bus_pkg::ADDR_W-1:0] gb_addr;
    logic [bus_pkg::DATA_W-1:0] gb_wdata;
    logic                       gb_busy;
    logic [bus_pkg::DATA_W-1:0] gb_rdata;
    logic                       gb_error;

    // one request register per hart
    genvar hart_id;
    generate
        for (hart_id = 0; hart_id < NUM_HARTS; hart_id = hart_id + 1) begin : GEN_HART
            front_side_port port_i (
                .CLK(CLK),
                .rst(rst),
                .req(req[hart_id]),
                .wen(wen[hart_id]),
                .addr(addr[hart_id]),
                .wdata(wdata[hart_id]),
                .done(done[hart_id]),
                .rdata(rdata[hart_id]),
                .error(error[hart_id]),
                .grant_done(port_grant_done[hart_id]),
                .resp_rdata(port_rdata[hart_id]),
                .resp_error(port_error[hart_id]),
                .port_valid(port_valid[hart_id]),
                .port_wen(port_wen[hart_id]),
                .port_addr(port_addr[hart_id]),
                .port_wdata(port_wdata[hart_id])
            );
        end
    endgenerate

    memory_controller #(
        .NUM_HARTS(NUM_HARTS)
    ) mc (
        .CLK(CLK),
        .rst(rst),
        .port_valid(port_valid),
        .port_wen(port_wen),
        .port_addr(port_addr),
        .port_wdata(port_wdata),
        .port_grant_done(port_grant_done),
        .port_rdata(port_rdata),
        .port_error(port_error),
        .gb_busy(gb_busy),
        .gb_rdata(gb_rdata),
        .gb_error(gb_error),
        .gb_ren(gb_ren),
        .gb_wen(gb_wen),
        .gb_addr(gb_addr),
        .gb_wdata(gb_wdata)
    );

    // APB side of the single memory path
    apb_requester bt (
        .CLK(CLK),
        .rst(rst),
        .gb_ren(gb_ren),
        .gb_wen(gb_wen),
        .gb_addr(gb_addr),
        .gb_wdata(gb_wdata),
        .gb_busy(gb_busy),
        .gb_rdata(gb_rdata),
        .gb_error(gb_error),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata)
    );

endmodule
